// ==== common/backEndPkg.sv ====
package backEndPkg;

   // ************************************************************************
   // encodings shared by the execute, memory and writeback stages
   // ************************************************************************

   typedef enum logic [3:0] {
      aluAdd   = 4'd0,
      aluSub   = 4'd1,
      aluAnd   = 4'd2,
      aluOr    = 4'd3,
      aluXor   = 4'd4,
      aluSll   = 4'd5,
      aluSrl   = 4'd6,
      aluSra   = 4'd7,
      aluSlt   = 4'd8,
      aluSltu  = 4'd9,
      aluPassB = 4'd10   // lui passes the immediate through
   } aluOp_t;

   typedef enum logic [2:0] {
      brNone   = 3'd0,
      brEq     = 3'd1,
      brNe     = 3'd2,
      brLt     = 3'd3,
      brGe     = 3'd4,
      brLtu    = 3'd5,
      brGeu    = 3'd6,
      brAlways = 3'd7    // jal and jalr
   } brCond_t;

   typedef enum logic [1:0] {
      resAlu  = 2'd0,
      resMem  = 2'd1,
      resLink = 2'd2     // pc plus 4
   } resSel_t;

   typedef enum logic [1:0] {
      sizeByte = 2'd0,
      sizeHalf = 2'd1,
      sizeWord = 2'd2
   } memSize_t;

   // ************************************************************************
   // stage bundles
   // ************************************************************************

   typedef struct packed {
      logic        valid;
      logic [31:0] pc;
      logic [31:0] rs1Val;
      logic [31:0] rs2Val;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [4:0]  rd;
      logic [31:0] imm;
      aluOp_t      aluOp;
      logic        useImmB;
      logic        useJalrBase;
      brCond_t     brCond;
      logic        memRead;
      logic        memWrite;
      memSize_t    memSize;
      logic        memUnsigned;
      resSel_t     resSel;
      logic        rfWe;
   } idExBundle_t;

   typedef struct packed {
      logic        valid;
      logic [31:0] aluOut;
      logic [31:0] storeData;
      logic [31:0] linkPc;
      logic [4:0]  rd;
      logic        rfWe;
      resSel_t     resSel;
      logic        memRead;
      logic        memWrite;
      memSize_t    memSize;
      logic        memUnsigned;
      logic        takeBranch;
      logic [31:0] target;
   } exMemBundle_t;

   typedef struct packed {
      logic        valid;
      logic [4:0]  rd;
      logic        rfWe;
      resSel_t     resSel;
      logic [31:0] aluOut;
      logic [31:0] linkPc;
      logic [1:0]  byteOffset;
      memSize_t    memSize;
      logic        memUnsigned;
   } memWbBundle_t;

   typedef struct packed {
      logic        we;
      logic [4:0]  addr;
      logic [31:0] data;
   } rfWrite_t;

   typedef struct packed {
      logic        taken;
      logic [31:0] target;
   } redirect_t;

endpackage

// ==== memStage/dataRam.sv ====
`timescale 1ns/10ps

module dataRam #(
   parameter int ramWords = 256
) (
   input  logic                        CLK,
   input  logic [3:0]                  we,
   input  logic [$clog2(ramWords)-1:0] addr,
   input  logic [31:0]                 wdata,
   output logic [31:0]                 rdata
);

   logic [31:0] mem [ramWords];

   initial begin
      for (int i = 0; i < ramWords; i++) begin
         mem[i] = 32'd0;
      end
   end

   // read returns the old word when the same address is written
   always_ff @(posedge CLK) begin
      for (int b = 0; b < 4; b++) begin
         if (we[b]) begin
            mem[addr][8*b +: 8] <= wdata[8*b +: 8];
         end
      end
      rdata <= mem[addr];
   end

endmodule

// ==== memStage/memStage.sv ====
`timescale 1ns/10ps

module memStage #(
   parameter int ramWords = 256
) (
   input  logic                     CLK,
   input  logic                     RSTn,
   input  logic                     stall,
   input  backEndPkg::exMemBundle_t exMem,
   output backEndPkg::memWbBundle_t memWb,
   output logic [31:0]              ramRdata
);

   localparam int addrBits = $clog2(ramWords);

   logic [1:0]          byteOffset;
   logic [addrBits-1:0] wordAddr;
   logic [3:0]          byteEn;
   logic [31:0]         laneData;
   logic [3:0]          ramWe;

   // ************************************************************************
   // byte enables and store lanes
   // ************************************************************************

   always_comb begin
      byteOffset = exMem.aluOut[1:0];
      wordAddr   = exMem.aluOut[addrBits+1:2];
      case (exMem.memSize)
         backEndPkg::sizeByte: begin
            byteEn   = 4'b0001 << byteOffset;
            laneData = {4{exMem.storeData[7:0]}};
         end
         backEndPkg::sizeHalf: begin
            byteEn   = byteOffset[1] ? 4'b1100 : 4'b0011;
            laneData = {2{exMem.storeData[15:0]}};
         end
         default: begin
            byteEn   = 4'b1111;
            laneData = exMem.storeData;
         end
      endcase
      // a held store writes only once, on the cycle it leaves EX/MEM
      ramWe = (exMem.valid && exMem.memWrite && !stall && !RSTn) ? byteEn : 4'b0000;
   end

   dataRam #(
      .ramWords (ramWords)
   ) uDataRam (
      .CLK   (CLK),
      .we    (ramWe),
      .addr  (wordAddr),
      .wdata (laneData),
      .rdata (ramRdata)
   );

   // ************************************************************************
   // MEM/WB handoff
   // ************************************************************************

   always_comb begin
      if (stall) begin
         memWb = '0;                    // writeBack takes a bubble while EX/MEM holds
      end else begin
         memWb.valid       = exMem.valid;
         memWb.rd          = exMem.rd;
         memWb.rfWe        = exMem.rfWe;
         memWb.resSel      = exMem.resSel;
         memWb.aluOut      = exMem.aluOut;
         memWb.linkPc      = exMem.linkPc;
         memWb.byteOffset  = byteOffset;
         memWb.memSize     = exMem.memSize;
         memWb.memUnsigned = exMem.memUnsigned;
      end
   end

endmodule

// ==== rtl/backEndTop.sv ====
`timescale 1ns/10ps

module backEndTop #(
   parameter int ramWords = 256
) (
   input  logic                    CLK,
   input  logic                    RSTn,
   input  logic                    stall,
   input  logic                    flush,
   input  backEndPkg::idExBundle_t idEx,
   output backEndPkg::rfWrite_t    rfWrite,
   output backEndPkg::redirect_t   redirect
);

   backEndPkg::exMemBundle_t exNext;
   backEndPkg::exMemBundle_t exMem;
   backEndPkg::memWbBundle_t memWb;
   logic [31:0]              ramRdata;

   // ************************************************************************
   // execute, EX/MEM, memory access and writeback
   // ************************************************************************

   execUnit uExecUnit (
      .idEx    (idEx),
      .exMem   (exMem),
      .rfWrite (rfWrite),
      .exNext  (exNext)
   );

   exMemReg uExMemReg (
      .CLK    (CLK),
      .RSTn   (RSTn),
      .stall  (stall),
      .flush  (flush),
      .exNext (exNext),
      .exMem  (exMem)
   );

   memStage #(
      .ramWords (ramWords)
   ) uMemStage (
      .CLK      (CLK),
      .RSTn     (RSTn),
      .stall    (stall),
      .exMem    (exMem),
      .memWb    (memWb),
      .ramRdata (ramRdata)
   );

   writeBack uWriteBack (
      .CLK      (CLK),
      .RSTn     (RSTn),
      .memWb    (memWb),
      .ramRdata (ramRdata),
      .rfWrite  (rfWrite)
   );

   // redirect is resolved one cycle after the branch enters execute
   always_comb begin
      redirect.taken  = exMem.valid && exMem.takeBranch;
      redirect.target = exMem.target;
   end

endmodule

// ==== rtl/exMemReg.sv ====
`timescale 1ns/10ps

module exMemReg (
   input  logic                     CLK,
   input  logic                     RSTn,
   input  logic                     stall,
   input  logic                     flush,
   input  backEndPkg::exMemBundle_t exNext,
   output backEndPkg::exMemBundle_t exMem
);

   // ************************************************************************
   // EX/MEM pipeline register
   // ************************************************************************

   always_ff @(posedge CLK) begin
      if (RSTn || flush) begin
         exMem <= '0;                   // bubble with every field cleared
      end else if (!stall) begin
         exMem <= exNext;
      end
   end

endmodule

// ==== rtl/execUnit.sv ====
`timescale 1ns/10ps

module execUnit (
   input  backEndPkg::idExBundle_t  idEx,
   input  backEndPkg::exMemBundle_t exMem,
   input  backEndPkg::rfWrite_t     rfWrite,
   output backEndPkg::exMemBundle_t exNext
);

   logic        exFwdOk;
   logic [31:0] exFwdVal;
   logic [31:0] rs1Fwd;
   logic [31:0] rs2Fwd;
   logic [31:0] opB;
   logic [4:0]  shamt;
   logic [31:0] aluResult;
   logic        takeBranch;
   logic [31:0] target;

   // ************************************************************************
   // operand forwarding
   // ************************************************************************

   // loads are still in flight in EX/MEM so they never forward from there
   always_comb begin
      exFwdOk  = exMem.valid && exMem.rfWe && (exMem.rd != 5'd0) && !exMem.memRead;
      exFwdVal = (exMem.resSel == backEndPkg::resLink) ? exMem.linkPc : exMem.aluOut;
   end

   always_comb begin
      rs1Fwd = idEx.rs1Val;
      if (exFwdOk && (exMem.rd == idEx.rs1)) begin
         rs1Fwd = exFwdVal;                    // youngest result wins
      end else if (rfWrite.we && (rfWrite.addr == idEx.rs1)) begin
         rs1Fwd = rfWrite.data;
      end

      rs2Fwd = idEx.rs2Val;
      if (exFwdOk && (exMem.rd == idEx.rs2)) begin
         rs2Fwd = exFwdVal;
      end else if (rfWrite.we && (rfWrite.addr == idEx.rs2)) begin
         rs2Fwd = rfWrite.data;
      end
   end

   // ************************************************************************
   // ALU and branch unit
   // ************************************************************************

   always_comb begin
      opB   = idEx.useImmB ? idEx.imm : rs2Fwd;
      shamt = opB[4:0];
      case (idEx.aluOp)
         backEndPkg::aluAdd:   aluResult = rs1Fwd + opB;
         backEndPkg::aluSub:   aluResult = rs1Fwd - opB;
         backEndPkg::aluAnd:   aluResult = rs1Fwd & opB;
         backEndPkg::aluOr:    aluResult = rs1Fwd | opB;
         backEndPkg::aluXor:   aluResult = rs1Fwd ^ opB;
         backEndPkg::aluSll:   aluResult = rs1Fwd << shamt;
         backEndPkg::aluSrl:   aluResult = rs1Fwd >> shamt;
         backEndPkg::aluSra:   aluResult = $unsigned($signed(rs1Fwd) >>> shamt);
         backEndPkg::aluSlt:   aluResult = {31'd0, $signed(rs1Fwd) < $signed(opB)};
         backEndPkg::aluSltu:  aluResult = {31'd0, rs1Fwd < opB};
         backEndPkg::aluPassB: aluResult = opB;
         default:              aluResult = 32'd0;
      endcase
   end

   // branches always compare the two registers, never the immediate
   always_comb begin
      case (idEx.brCond)
         backEndPkg::brEq:     takeBranch = (rs1Fwd == rs2Fwd);
         backEndPkg::brNe:     takeBranch = (rs1Fwd != rs2Fwd);
         backEndPkg::brLt:     takeBranch = $signed(rs1Fwd) < $signed(rs2Fwd);
         backEndPkg::brGe:     takeBranch = $signed(rs1Fwd) >= $signed(rs2Fwd);
         backEndPkg::brLtu:    takeBranch = rs1Fwd < rs2Fwd;
         backEndPkg::brGeu:    takeBranch = rs1Fwd >= rs2Fwd;
         backEndPkg::brAlways: takeBranch = 1'b1;
         default:              takeBranch = 1'b0;
      endcase
      target = idEx.useJalrBase ? ((rs1Fwd + idEx.imm) & ~32'd1) : (idEx.pc + idEx.imm);
   end

   always_comb begin
      exNext.valid       = idEx.valid;
      exNext.aluOut      = aluResult;
      exNext.storeData   = rs2Fwd;
      exNext.linkPc      = idEx.pc + 32'd4;
      exNext.rd          = idEx.rd;
      exNext.rfWe        = idEx.rfWe;
      exNext.resSel      = idEx.resSel;
      exNext.memRead     = idEx.memRead;
      exNext.memWrite    = idEx.memWrite;
      exNext.memSize     = idEx.memSize;
      exNext.memUnsigned = idEx.memUnsigned;
      exNext.takeBranch  = takeBranch;
      exNext.target      = target;
   end

endmodule

// ==== rtl/writeBack.sv ====
`timescale 1ns/10ps

module writeBack (
   input  logic                     CLK,
   input  logic                     RSTn,
   input  backEndPkg::memWbBundle_t memWb,
   input  logic [31:0]              ramRdata,
   output backEndPkg::rfWrite_t     rfWrite
);

   backEndPkg::memWbBundle_t wbReg;

   logic [31:0] shifted;
   logic [31:0] loadVal;
   logic [31:0] wbData;

   always_ff @(posedge CLK) begin
      if (RSTn) begin
         wbReg <= '0;
      end else begin
         wbReg <= memWb;
      end
   end

   // ************************************************************************
   // load alignment and extension
   // ************************************************************************

   always_comb begin
      shifted = ramRdata >> {wbReg.byteOffset, 3'b000};   // addressed lane down to bit 0
      case (wbReg.memSize)
         backEndPkg::sizeByte: begin
            loadVal = wbReg.memUnsigned ? {24'd0, shifted[7:0]}
                                        : {{24{shifted[7]}}, shifted[7:0]};
         end
         backEndPkg::sizeHalf: begin
            loadVal = wbReg.memUnsigned ? {16'd0, shifted[15:0]}
                                        : {{16{shifted[15]}}, shifted[15:0]};
         end
         default: loadVal = ramRdata;
      endcase
   end

   always_comb begin
      case (wbReg.resSel)
         backEndPkg::resMem:  wbData = loadVal;
         backEndPkg::resLink: wbData = wbReg.linkPc;
         default:             wbData = wbReg.aluOut;
      endcase
      rfWrite.we   = wbReg.valid && wbReg.rfWe && (wbReg.rd != 5'd0);   // x0 stays zero
      rfWrite.addr = wbReg.rd;
      rfWrite.data = wbData;
   end

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile and run the back-end testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module backEndTb \
   -f src.f -o simv
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulator exited with status $status"
   exit 1
fi

if grep -q "SIMULATION PASSED" sim.log; then
   exit 0
fi
exit 1

// ==== src.f ====
common/backEndPkg.sv
rtl/execUnit.sv
rtl/exMemReg.sv
memStage/dataRam.sv
memStage/memStage.sv
rtl/writeBack.sv
rtl/backEndTop.sv
verif/backEnd_assertions.sv
verif/backEndTb.sv

// ==== verif/backEndTb.sv ====
`timescale 1ns/10ps

module backEndTb;

   typedef struct {
      string                   name;
      backEndPkg::idExBundle_t idEx;
      logic                    stall;
      logic                    flush;
      backEndPkg::rfWrite_t    expRf;
      backEndPkg::redirect_t   expRedir;
   } row_t;

   logic                    CLK;
   logic                    RSTn;
   logic                    stall;
   logic                    flush;
   backEndPkg::idExBundle_t idEx;
   backEndPkg::rfWrite_t    rfWrite;
   backEndPkg::redirect_t   redirect;

   row_t                    rows[$];
   logic [31:0]             archRegs [32];   // program-order register state
   logic [31:0]             rfRegs [32];     // what the external register file holds
   logic [31:0]             memModel [256];
   backEndPkg::rfWrite_t    exWr;
   backEndPkg::rfWrite_t    wbWr;
   backEndPkg::redirect_t   exBr;
   logic [31:0]             pcNext;
   integer                  seed;
   int                      passCount;
   int                      failCount;
   int                      waitCycles;

   backEndTop #(
      .ramWords (256)
   ) DUT (
      .CLK      (CLK),
      .RSTn     (RSTn),
      .stall    (stall),
      .flush    (flush),
      .idEx     (idEx),
      .rfWrite  (rfWrite),
      .redirect (redirect)
   );

   bind exMemReg backEnd_assertions uExMemChecks (
      .CLK   (CLK),
      .RSTn  (RSTn),
      .stall (stall),
      .flush (flush),
      .exMem (exMem)
   );

   always #50 CLK = ~CLK;

   // ************************************************************************
   // reference model
   // ************************************************************************

   function automatic logic [31:0] aluRef(backEndPkg::aluOp_t op, logic [31:0] a, logic [31:0] b);
      case (op)
         backEndPkg::aluAdd:  return a + b;
         backEndPkg::aluSub:  return a - b;
         backEndPkg::aluAnd:  return a & b;
         backEndPkg::aluOr:   return a | b;
         backEndPkg::aluXor:  return a ^ b;
         backEndPkg::aluSll:  return a << b[4:0];
         backEndPkg::aluSrl:  return a >> b[4:0];
         backEndPkg::aluSra:  return $unsigned($signed(a) >>> b[4:0]);
         backEndPkg::aluSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         backEndPkg::aluSltu: return (a < b) ? 32'd1 : 32'd0;
         default:             return b;
      endcase
   endfunction

   function automatic logic brRef(backEndPkg::brCond_t c, logic [31:0] a, logic [31:0] b);
      case (c)
         backEndPkg::brEq:     return a == b;
         backEndPkg::brNe:     return a != b;
         backEndPkg::brLt:     return $signed(a) < $signed(b);
         backEndPkg::brGe:     return $signed(a) >= $signed(b);
         backEndPkg::brLtu:    return a < b;
         backEndPkg::brGeu:    return a >= b;
         backEndPkg::brAlways: return 1'b1;
         default:              return 1'b0;
      endcase
   endfunction

   function automatic logic [31:0] loadRef(logic [31:0] addr, backEndPkg::memSize_t size,
                                           logic uns);
      logic [31:0] word;
      logic [7:0]  bt;
      logic [15:0] hw;
      word = memModel[addr[9:2]];
      bt   = word[8*addr[1:0] +: 8];
      hw   = word[16*addr[1] +: 16];
      case (size)
         backEndPkg::sizeByte: return uns ? {24'd0, bt} : {{24{bt[7]}}, bt};
         backEndPkg::sizeHalf: return uns ? {16'd0, hw} : {{16{hw[15]}}, hw};
         default:              return word;
      endcase
   endfunction

   task automatic storeRef(input logic [31:0] addr, input backEndPkg::memSize_t size,
                           input logic [31:0] data);
      case (size)
         backEndPkg::sizeByte: memModel[addr[9:2]][8*addr[1:0] +: 8] = data[7:0];
         backEndPkg::sizeHalf: memModel[addr[9:2]][16*addr[1] +: 16] = data[15:0];
         default:              memModel[addr[9:2]] = data;
      endcase
   endtask

   task automatic execModel(input backEndPkg::idExBundle_t ins,
                            output backEndPkg::rfWrite_t wr, output backEndPkg::redirect_t br);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [31:0] data;
      a    = archRegs[ins.rs1];
      b    = archRegs[ins.rs2];
      res  = aluRef(ins.aluOp, a, ins.useImmB ? ins.imm : b);
      data = res;
      if (ins.memWrite) storeRef(res, ins.memSize, b);
      if (ins.resSel == backEndPkg::resMem) data = loadRef(res, ins.memSize, ins.memUnsigned);
      else if (ins.resSel == backEndPkg::resLink) data = ins.pc + 32'd4;
      wr.we   = ins.rfWe && (ins.rd != 5'd0);
      wr.addr = ins.rd;
      wr.data = data;
      if (wr.we) archRegs[ins.rd] = data;
      br.taken  = brRef(ins.brCond, a, b);
      br.target = ins.useJalrBase ? ((a + ins.imm) & ~32'd1) : (ins.pc + ins.imm);
   endtask

   // one clock edge of the pipeline model, expected values are what follows that edge
   task automatic addRow(input string name, input backEndPkg::idExBundle_t ins,
                         input logic st, input logic fl);
      row_t                  r;
      backEndPkg::rfWrite_t  accWr;
      backEndPkg::redirect_t accBr;
      accWr       = '0;
      accBr       = '0;
      ins.rs1Val  = rfRegs[ins.rs1];
      ins.rs2Val  = rfRegs[ins.rs2];
      if (wbWr.we) rfRegs[wbWr.addr] = wbWr.data;
      if (!st && !fl && ins.valid) execModel(ins, accWr, accBr);
      wbWr = st ? '0 : exWr;
      if (fl) begin
         exWr = '0;
         exBr = '0;
      end else if (!st) begin
         exWr = accWr;
         exBr = accBr;
      end
      r.name     = name;
      r.idEx     = ins;
      r.stall    = st;
      r.flush    = fl;
      r.expRf    = wbWr;
      r.expRedir = exBr;
      rows.push_back(r);
   endtask

   // ************************************************************************
   // instruction builders and stimulus table
   // ************************************************************************

   function automatic backEndPkg::idExBundle_t newInstr();
      backEndPkg::idExBundle_t i;
      i       = '0;
      i.valid = 1'b1;
      i.pc    = pcNext;
      pcNext  = pcNext + 32'd4;
      return i;
   endfunction

   function automatic backEndPkg::idExBundle_t aluInstr(backEndPkg::aluOp_t op, logic [4:0] rd,
      logic [4:0] rs1, logic [4:0] rs2, logic useImm, logic [31:0] imm);
      backEndPkg::idExBundle_t i;
      i         = newInstr();
      i.aluOp   = op;
      i.rd      = rd;
      i.rs1     = rs1;
      i.rs2     = rs2;
      i.useImmB = useImm;
      i.imm     = imm;
      i.rfWe    = 1'b1;
      return i;
   endfunction

   function automatic backEndPkg::idExBundle_t memInstr(logic store,
      backEndPkg::memSize_t size, logic uns, logic [4:0] regNum, logic [31:0] addr);
      backEndPkg::idExBundle_t i;
      i         = aluInstr(backEndPkg::aluAdd, 5'd0, 5'd0, 5'd0, 1'b1, addr);
      i.memSize = size;
      if (store) begin
         i.memWrite = 1'b1;
         i.rfWe     = 1'b0;
         i.rs2      = regNum;
      end else begin
         i.memRead     = 1'b1;
         i.rd          = regNum;
         i.resSel      = backEndPkg::resMem;
         i.memUnsigned = uns;
      end
      return i;
   endfunction

   function automatic backEndPkg::idExBundle_t brInstr(backEndPkg::brCond_t c, logic [4:0] rs1,
      logic [4:0] rs2, logic [4:0] rd, logic jalr, logic [31:0] imm);
      backEndPkg::idExBundle_t i;
      i             = newInstr();
      i.brCond      = c;
      i.rs1         = rs1;
      i.rs2         = rs2;
      i.imm         = imm;
      i.useJalrBase = jalr;
      if (c == backEndPkg::brAlways) begin
         i.rfWe   = 1'b1;
         i.rd     = rd;
         i.resSel = backEndPkg::resLink;
      end
      return i;
   endfunction

   function automatic logic [4:0] pickReg(int span);
      logic [31:0] r;
      r = $random(seed);
      return 5'(r % span);
   endfunction

   task automatic buildTable();
      backEndPkg::idExBundle_t nop;
      logic [31:0]             v;
      logic [4:0]              ra;
      nop = '0;
      for (int r = 1; r < 16; r++) begin
         v = $random(seed);
         addRow("init", aluInstr(backEndPkg::aluPassB, 5'(r), 5'd0, 5'd0, 1'b1, v), 1'b0, 1'b0);
      end
      for (int op = 0; op < 11; op++) begin
         for (int im = 0; im < 2; im++) begin
            v = $random(seed);
            addRow($sformatf("alu op%0d imm%0d", op, im),
                   aluInstr(backEndPkg::aluOp_t'(op), 5'd1 + pickReg(7), pickReg(8), pickReg(8),
                            1'(im), v), 1'b0, 1'b0);
         end
      end
      addRow("alu rd zero", aluInstr(backEndPkg::aluAdd, 5'd0, 5'd1, 5'd2, 1'b0, 0), 1'b0, 1'b0);
      for (int n = 0; n < 3; n++) begin
         addRow("fwd exmem", aluInstr(backEndPkg::aluAdd, 5'd3, 5'd3, 5'd3, 1'b0, 0), 1'b0, 1'b0);
      end
      addRow("fwd a", aluInstr(backEndPkg::aluAdd, 5'd4, 5'd3, 5'd0, 1'b1, 1), 1'b0, 1'b0);
      addRow("fwd b", aluInstr(backEndPkg::aluXor, 5'd5, 5'd1, 5'd2, 1'b0, 0), 1'b0, 1'b0);
      addRow("fwd memwb", aluInstr(backEndPkg::aluSub, 5'd6, 5'd4, 5'd4, 1'b1, 7), 1'b0, 1'b0);

      addRow("store word", memInstr(1'b1, backEndPkg::sizeWord, 1'b0, 5'd7, 32'h40), 1'b0, 1'b0);
      for (int o = 0; o < 4; o++) begin
         addRow("store byte", memInstr(1'b1, backEndPkg::sizeByte, 1'b0, 5'd8 + 5'(o),
                32'h50 + o), 1'b0, 1'b0);
      end
      addRow("store half", memInstr(1'b1, backEndPkg::sizeHalf, 1'b0, 5'd12, 32'h60), 1'b0, 1'b0);
      addRow("store half", memInstr(1'b1, backEndPkg::sizeHalf, 1'b0, 5'd13, 32'h62), 1'b0, 1'b0);
      for (int o = 0; o < 4; o++) begin
         for (int u = 0; u < 2; u++) begin
            addRow($sformatf("load byte off%0d u%0d", o, u), memInstr(1'b0,
                   backEndPkg::sizeByte, 1'(u), 5'd20 + 5'(o), 32'h40 + o), 1'b0, 1'b0);
            addRow($sformatf("load sbyte off%0d u%0d", o, u), memInstr(1'b0,
                   backEndPkg::sizeByte, 1'(u), 5'd24 + 5'(o), 32'h50 + o), 1'b0, 1'b0);
         end
      end
      for (int o = 0; o < 4; o += 2) begin
         for (int u = 0; u < 2; u++) begin
            addRow($sformatf("load half off%0d u%0d", o, u), memInstr(1'b0,
                   backEndPkg::sizeHalf, 1'(u), 5'd21, 32'h60 + o), 1'b0, 1'b0);
         end
      end
      addRow("load word", memInstr(1'b0, backEndPkg::sizeWord, 1'b0, 5'd22, 32'h40), 1'b0, 1'b0);

      for (int c = 1; c < 7; c++) begin
         v  = $random(seed);
         ra = 5'd1 + pickReg(15);
         addRow($sformatf("branch cond%0d", c), brInstr(backEndPkg::brCond_t'(c), ra,
                5'd1 + pickReg(15), 5'd0, 1'b0, {20'd0, v[11:1], 1'b0}), 1'b0, 1'b0);
         addRow($sformatf("branch cond%0d same", c), brInstr(backEndPkg::brCond_t'(c), ra, ra,
                5'd0, 1'b0, {20'd0, v[12:2], 1'b0}), 1'b0, 1'b0);
      end
      addRow("jal", brInstr(backEndPkg::brAlways, 5'd0, 5'd0, 5'd9, 1'b0, 32'h100), 1'b0, 1'b0);
      addRow("jalr", brInstr(backEndPkg::brAlways, 5'd9, 5'd0, 5'd10, 1'b1, 32'h21), 1'b0, 1'b0);

      addRow("stalled store", memInstr(1'b1, backEndPkg::sizeWord, 1'b0, 5'd3, 32'h80), 1'b0, 1'b0);
      addRow("stall 1", nop, 1'b1, 1'b0);
      addRow("stall 2", nop, 1'b1, 1'b0);
      addRow("after stall", memInstr(1'b0, backEndPkg::sizeWord, 1'b0, 5'd23, 32'h80), 1'b0, 1'b0);
      addRow("stalled alu", aluInstr(backEndPkg::aluAdd, 5'd11, 5'd1, 5'd2, 1'b0, 0), 1'b0, 1'b0);
      addRow("stall 3", nop, 1'b1, 1'b0);
      addRow("stall 4", nop, 1'b1, 1'b0);
      addRow("after stall alu", aluInstr(backEndPkg::aluOr, 5'd12, 5'd11, 5'd11, 1'b0, 0),
             1'b0, 1'b0);
      addRow("flushed alu", aluInstr(backEndPkg::aluPassB, 5'd5, 5'd0, 5'd0, 1'b1, 32'h55),
             1'b0, 1'b1);
      addRow("flushed jal", brInstr(backEndPkg::brAlways, 5'd0, 5'd0, 5'd6, 1'b0, 32'h40),
             1'b0, 1'b1);
      addRow("use after flush", aluInstr(backEndPkg::aluAdd, 5'd13, 5'd5, 5'd6, 1'b0, 0),
             1'b0, 1'b0);
      // this one sits in EX/MEM when flush and stall arrive together and must vanish
      addRow("killed by flush", aluInstr(backEndPkg::aluAdd, 5'd15, 5'd1, 5'd2, 1'b0, 0),
             1'b0, 1'b0);
      addRow("flush with stall", aluInstr(backEndPkg::aluAdd, 5'd14, 5'd1, 5'd1, 1'b0, 0),
             1'b1, 1'b1);
      addRow("drain 1", nop, 1'b0, 1'b0);
      addRow("drain 2", nop, 1'b0, 1'b0);
   endtask

   // ************************************************************************
   // driver and checks
   // ************************************************************************

   task automatic checkRow(input row_t r);
      logic ok;
      ok = 1'b1;
      if ((rfWrite.we !== r.expRf.we) || (r.expRf.we && ((rfWrite.addr !== r.expRf.addr)
          || (rfWrite.data !== r.expRf.data)))) begin
         $display(
            "CHECK FAILED %s rfWrite expected we=%0b rd=%0d data=%h actual we=%0b rd=%0d data=%h",
            r.name, r.expRf.we, r.expRf.addr, r.expRf.data,
            rfWrite.we, rfWrite.addr, rfWrite.data);
         ok = 1'b0;
      end
      if ((redirect.taken !== r.expRedir.taken)
          || (r.expRedir.taken && (redirect.target !== r.expRedir.target))) begin
         $display("CHECK FAILED %s redirect expected taken=%0b target=%h actual taken=%0b target=%h",
                  r.name, r.expRedir.taken, r.expRedir.target, redirect.taken, redirect.target);
         ok = 1'b0;
      end
      if (ok) begin
         passCount++;
         $display("pass  %s", r.name);
      end else begin
         failCount++;
         $display("fail  %s", r.name);
      end
   endtask

   initial begin
      CLK  = 1'b0;
      RSTn = 1'b1;                    // reset is asserted while high
      repeat (2) @(posedge CLK);
      #1 RSTn = 1'b0;
   end

   initial begin
      stall      = 1'b0;
      flush      = 1'b0;
      idEx       = '0;
      seed       = 32'he26cbef1;
      pcNext     = 32'h1000;
      passCount  = 0;
      failCount  = 0;
      waitCycles = 0;
      exWr       = '0;
      wbWr       = '0;
      exBr       = '0;
      for (int i = 0; i < 32; i++) begin
         archRegs[i] = 32'd0;
         rfRegs[i]   = 32'd0;
      end
      for (int i = 0; i < 256; i++) begin
         memModel[i] = 32'd0;
      end
      buildTable();
      while (RSTn && (waitCycles < 10)) begin
         @(negedge CLK);
         waitCycles++;
      end
      if (RSTn) begin
         $display("reset was still asserted after %0d cycles", waitCycles);
         failCount++;
      end else begin
         @(posedge CLK);
         #1;
         foreach (rows[k]) begin
            idEx  = rows[k].idEx;
            stall = rows[k].stall;
            flush = rows[k].flush;
            @(posedge CLK);
            #1;
            checkRow(rows[k]);
         end
      end
      $display("tests: %0d passed, %0d failed", passCount, failCount);
      if (failCount == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== verif/backEnd_assertions.sv ====
`timescale 1ns/10ps

module backEnd_assertions (
   input logic                     CLK,
   input logic                     RSTn,
   input logic                     stall,
   input logic                     flush,
   input backEndPkg::exMemBundle_t exMem
);

   // ************************************************************************
   // EX/MEM register rules
   // ************************************************************************

   property flushGivesBubble;
      @(posedge CLK) flush |=> (exMem == '0);
   endproperty

   property stallHolds;
      @(posedge CLK) (!RSTn && stall && !flush) |=> $stable(exMem);
   endproperty

   property resetClearsControl;
      @(posedge CLK) RSTn |=> (!exMem.valid && !exMem.rfWe && !exMem.memRead
                               && !exMem.memWrite && !exMem.takeBranch);
   endproperty

   assert property (flushGivesBubble) else $error("EX/MEM not a bubble after flush");
   assert property (stallHolds) else $error("EX/MEM changed while stalled");
   assert property (resetClearsControl) else $error("EX/MEM control set after reset");

endmodule
